//--- Bender.yml
package:
  name: bpu

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/bpu_addr_pkg.sv
      - hw/bpu_counter_pkg.sv
      - hw/branch_target_buffer.sv
      - hw/gshare_predictor.sv
      - hw/fetch_redirect.sv
      - hw/bpu_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - test/tb_bpu_top.sv

//--- hw/bpu_addr_pkg.sv
// Address typedefs: fetch address, target-buffer index and tag, counter-table index

`include "bpu_cfg.svh"

package bpu_addr_pkg;

    // A fetch address or a branch target
    typedef logic [`BPU_PC_WIDTH-1:0] pc_t;

    // Target-buffer index, taken from the address just above the two byte-offset bits
    typedef logic [$clog2(`BPU_BTB_ENTRIES)-1:0] btb_idx_t;

    // Everything above the index forms the tag
    typedef logic [`BPU_PC_WIDTH-$clog2(`BPU_BTB_ENTRIES)-3:0] btb_tag_t;

    // Counter-table index, also taken from address bit 2 upward
    typedef logic [$clog2(`BPU_PHT_ENTRIES)-1:0] pht_idx_t;

endpackage : bpu_addr_pkg

//--- hw/bpu_cfg.svh
// Configuration macros for the branch prediction unit: address width, table sizes, FIFO depth

`ifndef BPU_CFG_SVH
`define BPU_CFG_SVH

// ==========================================================================
// Sizing of the prediction structures
// ==========================================================================

// Width of fetch, resolved and target addresses
`define BPU_PC_WIDTH 32

// Entries of the direct-mapped branch target buffer, a power of two
`define BPU_BTB_ENTRIES 64

// Two-bit counters in the gshare table, also sets the history length
`define BPU_PHT_ENTRIES 1024

// Predictions that may wait for resolution, a power of two
`define BPU_FIFO_DEPTH 8

`endif

//--- hw/bpu_counter_pkg.sv
// Direction-predictor types: two-bit saturating counter enum and global history

`include "bpu_cfg.svh"

package bpu_counter_pkg;

    // Two-bit saturating counter
    // The upper bit set means the branch is predicted taken
    typedef enum logic [1:0] {
        STRONG_NT = 2'b00,
        WEAK_NT   = 2'b01,
        WEAK_T    = 2'b10,
        STRONG_T  = 2'b11
    } counter_t;

    // Global history of resolved outcomes, newest outcome in bit 0
    // Its length equals the counter-table index width so that the two can be XORed
    typedef logic [$clog2(`BPU_PHT_ENTRIES)-1:0] ghr_t;

endpackage : bpu_counter_pkg

//--- hw/bpu_top.sv
// Branch prediction unit top level: target buffer, gshare predictor and redirect selector

`include "bpu_cfg.svh"

module bpu_top (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              stall_i,
    input  logic              flush_i,

    // Resolution from execute, one strobe per conditional branch
    input  logic              executed_i,
    input  logic              taken_i,

    input  bpu_addr_pkg::pc_t fetch_pc_i,
    input  bpu_addr_pkg::pc_t resolved_pc_i,
    input  bpu_addr_pkg::pc_t resolved_target_i,

    output bpu_addr_pkg::pc_t next_pc_o,
    output logic              prediction_o,
    output logic              mispredicted_o
);

    import bpu_addr_pkg::*;

    logic btb_hit;
    pc_t  btb_target;

    // Only taken branches allocate, a not-taken one needs no target
    branch_target_buffer i_btb (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .lookup_pc_i     (fetch_pc_i),
        .hit_o           (btb_hit),
        .target_o        (btb_target),
        .update_i        (executed_i & taken_i),
        .update_pc_i     (resolved_pc_i),
        .update_target_i (resolved_target_i)
    );

    // Direction is predicted only for addresses known to hold a branch
    gshare_predictor i_gshare (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .stall_i        (stall_i),
        .flush_i        (flush_i),
        .predict_i      (btb_hit),
        .executed_i     (executed_i),
        .taken_i        (taken_i),
        .fetch_pc_i     (fetch_pc_i),
        .prediction_o   (prediction_o),
        .mispredicted_o (mispredicted_o)
    );

    fetch_redirect i_redirect (
        .fetch_pc_i        (fetch_pc_i),
        .btb_target_i      (btb_target),
        .resolved_pc_i     (resolved_pc_i),
        .resolved_target_i (resolved_target_i),
        .btb_hit_i         (btb_hit),
        .prediction_i      (prediction_o),
        .mispredicted_i    (mispredicted_o),
        .taken_i           (taken_i),
        .next_pc_o         (next_pc_o)
    );

endmodule : bpu_top

//--- hw/branch_target_buffer.sv
// Direct-mapped branch target buffer with combinational lookup and resolved-branch update

`include "bpu_cfg.svh"

module branch_target_buffer (
    input  logic              clk_i,
    input  logic              rst_n_i,

    // Lookup port, driven by the fetch address
    input  bpu_addr_pkg::pc_t lookup_pc_i,
    output logic              hit_o,
    output bpu_addr_pkg::pc_t target_o,

    // Update port, driven by taken branches from execute
    input  logic              update_i,
    input  bpu_addr_pkg::pc_t update_pc_i,
    input  bpu_addr_pkg::pc_t update_target_i
);

    import bpu_addr_pkg::*;

    // Index sits just above the byte offset, the tag fills the rest of the address
    localparam int unsigned IDX_W = $bits(btb_idx_t);
    localparam int unsigned IDX_LO = 2;
    localparam int unsigned TAG_LO = IDX_LO + IDX_W;

    // ==========================================================================
    // Storage
    // ==========================================================================

    logic     valid_q  [`BPU_BTB_ENTRIES];
    btb_tag_t tag_q    [`BPU_BTB_ENTRIES];
    pc_t      target_q [`BPU_BTB_ENTRIES];

    btb_idx_t lookup_idx;
    btb_tag_t lookup_tag;
    btb_idx_t update_idx;
    btb_tag_t update_tag;

    // Split both addresses into index and tag
    assign lookup_idx = lookup_pc_i[TAG_LO-1:IDX_LO];
    assign lookup_tag = lookup_pc_i[`BPU_PC_WIDTH-1:TAG_LO];
    assign update_idx = update_pc_i[TAG_LO-1:IDX_LO];
    assign update_tag = update_pc_i[`BPU_PC_WIDTH-1:TAG_LO];

    // ==========================================================================
    // Lookup
    // ==========================================================================

    // A hit needs a valid entry whose tag matches the fetch address
    // The target is passed through even on a miss, the selector ignores it then
    assign hit_o    = valid_q[lookup_idx] && (tag_q[lookup_idx] == lookup_tag);
    assign target_o = target_q[lookup_idx];

    // ==========================================================================
    // Update
    // ==========================================================================

    // Valid bits are control state and start out cleared
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `BPU_BTB_ENTRIES; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (update_i) begin
            valid_q[update_idx] <= 1'b1;
        end
    end

    // Tag and target of an entry are replaced as a whole
    // A new branch mapping to the same index simply evicts the old one
    always_ff @(posedge clk_i) begin
        if (update_i) begin
            tag_q[update_idx]    <= update_tag;
            target_q[update_idx] <= update_target_i;
        end
    end

    // Written entries become visible to lookup from the following cycle on,
    // there is no bypass from the update port

endmodule : branch_target_buffer

//--- hw/fetch_redirect.sv
// Next-fetch-address selector between sequential, predicted and corrected paths

`include "bpu_cfg.svh"

module fetch_redirect (
    input  bpu_addr_pkg::pc_t fetch_pc_i,
    input  bpu_addr_pkg::pc_t btb_target_i,
    input  bpu_addr_pkg::pc_t resolved_pc_i,
    input  bpu_addr_pkg::pc_t resolved_target_i,
    input  logic              btb_hit_i,
    input  logic              prediction_i,
    input  logic              mispredicted_i,
    input  logic              taken_i,
    output bpu_addr_pkg::pc_t next_pc_o
);

    import bpu_addr_pkg::*;

    // Fixed instruction size of the fetch stage
    localparam pc_t INSTR_BYTES = (`BPU_PC_WIDTH)'(4);

    pc_t correct_pc;

    // The correct path is the target of a taken branch, else its fall-through
    assign correct_pc = taken_i ? resolved_target_i : (resolved_pc_i + INSTR_BYTES);

    // Correction overrides any prediction made for the current fetch
    always_comb begin
        if (mispredicted_i) begin
            next_pc_o = correct_pc;
        end else if (btb_hit_i && prediction_i) begin
            next_pc_o = btb_target_i;
        end else begin
            next_pc_o = fetch_pc_i + INSTR_BYTES;
        end
    end

endmodule : fetch_redirect

//--- hw/gshare_predictor.sv
// Gshare direction predictor: global history, counter table and pending-prediction FIFO

`include "bpu_cfg.svh"

module gshare_predictor (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              stall_i,
    input  logic              flush_i,

    // Target buffer hit, a prediction is made for this fetch
    input  logic              predict_i,

    // Resolution of the oldest conditional branch
    input  logic              executed_i,
    input  logic              taken_i,

    input  bpu_addr_pkg::pc_t fetch_pc_i,

    output logic              prediction_o,
    output logic              mispredicted_o
);

    import bpu_addr_pkg::*;
    import bpu_counter_pkg::*;

    localparam int unsigned IDX_W = $bits(pht_idx_t);
    localparam int unsigned GHR_W = $bits(ghr_t);
    localparam int unsigned PTR_W = $clog2(`BPU_FIFO_DEPTH);
    localparam int unsigned CNT_W = $clog2(`BPU_FIFO_DEPTH + 1);

    // Saturating step of a counter toward the resolved outcome
    function automatic counter_t step_counter(counter_t cur, logic taken);
        counter_t nxt;
        case (cur)
            STRONG_NT: nxt = taken ? WEAK_NT  : STRONG_NT;
            WEAK_NT:   nxt = taken ? WEAK_T   : STRONG_NT;
            WEAK_T:    nxt = taken ? STRONG_T : WEAK_NT;
            default:   nxt = taken ? STRONG_T : WEAK_T;
        endcase
        return nxt;
    endfunction

    ghr_t     ghr_q;
    counter_t pht_q [`BPU_PHT_ENTRIES];
    pht_idx_t fetch_idx;
    pht_idx_t hash_idx;
    counter_t pred_cnt;
    counter_t train_cnt;

    // Pending FIFO, one direction bit and one table index per entry
    logic             fifo_dir_q [`BPU_FIFO_DEPTH];
    pht_idx_t         fifo_idx_q [`BPU_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             fifo_empty;
    logic             fifo_full;
    logic             push;
    logic             pop;
    logic             clear;

    // ==========================================================================
    // Prediction
    // ==========================================================================

    // The hash mixes the fetch address, not the target, with the history
    assign fetch_idx = fetch_pc_i[IDX_W+1:2];
    assign hash_idx  = fetch_idx ^ ghr_q;
    assign pred_cnt  = pht_q[hash_idx];

    // Without a target buffer hit there is nothing to predict
    assign prediction_o = predict_i & pred_cnt[1];

    // ==========================================================================
    // Pending-prediction FIFO
    // ==========================================================================

    assign fifo_empty = (count_q == '0);
    assign fifo_full  = (count_q == CNT_W'(`BPU_FIFO_DEPTH));

    // Stalled fetches are not queued, and a push into a full FIFO is lost
    assign push  = predict_i & ~stall_i & ~fifo_full;
    assign pop   = executed_i & ~fifo_empty;
    assign clear = mispredicted_o | flush_i;

    // Only a resolution that finds a queued prediction can mispredict
    assign mispredicted_o = pop & (taken_i != fifo_dir_q[rd_ptr_q]);

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || clear) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Entry payload, a push during a clear leaves a stale entry that is never read
    always_ff @(posedge clk_i) begin
        if (push) begin
            fifo_dir_q[wr_ptr_q] <= prediction_o;
            fifo_idx_q[wr_ptr_q] <= hash_idx;
        end
    end

    // ==========================================================================
    // Training
    // ==========================================================================

    // The counter that made the oldest prediction moves one step toward the outcome
    assign train_cnt = step_counter(pht_q[fifo_idx_q[rd_ptr_q]], taken_i);

    // The table is written only for a resolution with a queued prediction;
    // a flush in the same cycle does not stop the update
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `BPU_PHT_ENTRIES; i++) begin
                pht_q[i] <= STRONG_NT;
            end
        end else if (pop) begin
            pht_q[fifo_idx_q[rd_ptr_q]] <= train_cnt;
        end
    end

    // Every resolved outcome enters the history, queued or not
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ghr_q <= '0;
        end else if (executed_i) begin
            ghr_q <= {ghr_q[GHR_W-2:0], taken_i};
        end
    end

endmodule : gshare_predictor

//--- test/tb_bpu_top.sv
// Testbench for the branch prediction unit: clock, reset, LFSR stimulus, reference model, checks

`include "bpu_cfg.svh"

module tb_bpu_top;

    timeunit 1ns;
    timeprecision 1ps;

    import bpu_addr_pkg::*;
    import bpu_counter_pkg::*;

    localparam int unsigned DIR_BIT       = $bits(pht_idx_t);
    localparam int unsigned TRAIN_TIMEOUT = 64;
    localparam int unsigned RANDOM_CYCLES = 3000;
    localparam pc_t         UNKNOWN_PC    = 32'h0000_2000;

    logic clk;
    logic rst_n;
    logic stall;
    logic flush;
    logic executed;
    logic taken;
    pc_t  fetch_pc;
    pc_t  resolved_pc;
    pc_t  resolved_target;
    pc_t  next_pc;
    logic prediction;
    logic mispredicted;

    // ==========================================================================
    // Reference model state
    // ==========================================================================

    logic             m_valid  [`BPU_BTB_ENTRIES];
    btb_tag_t         m_tag    [`BPU_BTB_ENTRIES];
    pc_t              m_target [`BPU_BTB_ENTRIES];
    logic [1:0]       m_pht    [`BPU_PHT_ENTRIES];
    ghr_t             m_ghr;
    // Each pending entry holds the predicted direction on top of the counter index
    logic [DIR_BIT:0] m_pending [$];

    logic        exp_hit;
    logic        exp_pred;
    logic        exp_mis;
    pc_t         exp_next;
    pht_idx_t    exp_hash;
    logic        seen_pred;
    logic        timed_out;
    logic [31:0] lfsr;
    int unsigned err_next;
    int unsigned err_pred;
    int unsigned err_mis;
    int unsigned err_other;

    bpu_top i_dut (
        .clk_i             (clk),
        .rst_n_i           (rst_n),
        .stall_i           (stall),
        .flush_i           (flush),
        .executed_i        (executed),
        .taken_i           (taken),
        .fetch_pc_i        (fetch_pc),
        .resolved_pc_i     (resolved_pc),
        .resolved_target_i (resolved_target),
        .next_pc_o         (next_pc),
        .prediction_o      (prediction),
        .mispredicted_o    (mispredicted)
    );

    always #10 clk = ~clk;

    // ==========================================================================
    // Output checks sampled just before each rising edge
    // ==========================================================================

    check_next_pc: assert property (@(posedge clk) disable iff (!rst_n) next_pc == exp_next)
        else begin
            err_next++;
            $display("ERROR %0t next_pc_o expected %h actual %h",
                     $time, $sampled(exp_next), $sampled(next_pc));
        end

    check_prediction: assert property (@(posedge clk) disable iff (!rst_n) prediction == exp_pred)
        else begin
            err_pred++;
            $display("ERROR %0t prediction_o expected %b actual %b",
                     $time, $sampled(exp_pred), $sampled(prediction));
        end

    check_mispredict: assert property (@(posedge clk) disable iff (!rst_n) mispredicted == exp_mis)
        else begin
            err_mis++;
            $display("ERROR %0t mispredicted_o expected %b actual %b",
                     $time, $sampled(exp_mis), $sampled(mispredicted));
        end

    // Galois LFSR stepped once per bit handed out
    function automatic logic [31:0] take_bits(int unsigned n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr  = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            value = {value[30:0], lfsr[0]};
        end
        return value;
    endfunction

    // Pool entries alternate between two index groups, so tags collide on an index
    function automatic pc_t pool_pc(int unsigned k);
        return 32'h0000_1000 + pc_t'(k) * 32'h0000_0180;
    endfunction

    // Model outputs for the inputs that were just driven
    task automatic compute_expected();
        btb_idx_t idx;
        idx      = fetch_pc[7:2];
        exp_hit  = m_valid[idx] && (m_tag[idx] == fetch_pc[31:8]);
        exp_hash = fetch_pc[11:2] ^ m_ghr;
        exp_pred = exp_hit && m_pht[exp_hash][1];
        exp_mis  = executed && (m_pending.size() != 0) && (taken != m_pending[0][DIR_BIT]);
        if (exp_mis) begin
            exp_next = taken ? resolved_target : resolved_pc + 32'd4;
        end else if (exp_pred) begin
            exp_next = m_target[idx];
        end else begin
            exp_next = fetch_pc + 32'd4;
        end
    endtask

    // Model state change at a rising edge from the inputs held over that edge
    task automatic update_model();
        logic             push;
        logic [DIR_BIT:0] head;
        btb_idx_t         idx;
        push = exp_hit && !stall && (m_pending.size() < `BPU_FIFO_DEPTH);
        if (executed && (m_pending.size() != 0)) begin
            head = m_pending.pop_front();
            // Saturating count toward the outcome
            if (taken && (m_pht[head[DIR_BIT-1:0]] != 2'b11)) begin
                m_pht[head[DIR_BIT-1:0]] = m_pht[head[DIR_BIT-1:0]] + 2'b01;
            end else if (!taken && (m_pht[head[DIR_BIT-1:0]] != 2'b00)) begin
                m_pht[head[DIR_BIT-1:0]] = m_pht[head[DIR_BIT-1:0]] - 2'b01;
            end
        end
        if (executed) begin
            m_ghr = {m_ghr[$bits(ghr_t)-2:0], taken};
        end
        if (executed && taken) begin
            idx           = resolved_pc[7:2];
            m_valid[idx]  = 1'b1;
            m_tag[idx]    = resolved_pc[31:8];
            m_target[idx] = resolved_target;
        end
        if (exp_mis || flush) begin
            m_pending.delete();
        end else if (push) begin
            m_pending.push_back({exp_pred, exp_hash});
        end
    endtask

    // Drive one cycle at the falling edge and advance the model at the rising one
    task automatic drive_cycle(pc_t pc, logic stall_v, logic flush_v, logic exec_v,
                               logic taken_v, pc_t rpc, pc_t rtgt);
        fetch_pc        = pc;
        stall           = stall_v;
        flush           = flush_v;
        executed        = exec_v;
        taken           = taken_v;
        resolved_pc     = rpc;
        resolved_target = rtgt;
        compute_expected();
        #1;
        seen_pred = prediction;
        @(posedge clk);
        update_model();
        @(negedge clk);
    endtask

    // Fetch at pc and resolve taken until the DUT predicts taken there
    task automatic train_until_taken(pc_t pc, pc_t tgt, output logic expired);
        int unsigned tries;
        tries = 0;
        drive_cycle(pc, 1'b0, 1'b0, 1'b0, 1'b0, pc, tgt);
        while (!seen_pred && (tries < TRAIN_TIMEOUT)) begin
            drive_cycle(UNKNOWN_PC, 1'b0, 1'b0, 1'b1, 1'b1, pc, tgt);
            drive_cycle(pc, 1'b0, 1'b0, 1'b0, 1'b0, pc, tgt);
            tries++;
        end
        expired = !seen_pred;
        if (expired) begin
            err_other++;
            $display("Timeout: prediction_o never went high for address %h", pc);
        end
    endtask

    // Mixed lookups, stalls, flushes and resolutions
    task automatic run_random();
        pc_t  pc_v;
        pc_t  rpc_v;
        pc_t  rtgt_v;
        logic stall_v;
        logic flush_v;
        logic exec_v;
        logic taken_v;
        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            pc_v    = (take_bits(3) == 0) ? pc_t'(take_bits(30) << 2) : pool_pc(take_bits(3));
            rpc_v   = pool_pc(take_bits(3));
            rtgt_v  = (take_bits(3) == 0) ? pc_t'(take_bits(30) << 2) : rpc_v + 32'h0000_0800;
            stall_v = (take_bits(3) == 0);
            flush_v = (take_bits(4) == 0);
            exec_v  = (take_bits(1) != 0);
            taken_v = (take_bits(1) != 0);
            drive_cycle(pc_v, stall_v, flush_v, exec_v, taken_v, rpc_v, rtgt_v);
        end
    endtask

    task automatic finish_run();
        $display("Errors: next_pc_o %0d, prediction_o %0d, mispredicted_o %0d, other %0d",
                 err_next, err_pred, err_mis, err_other);
        if ((err_next + err_pred + err_mis + err_other) == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    // ==========================================================================
    // Directed sequence followed by the random stream
    // ==========================================================================

    initial begin
        $timeformat(-9, 0, " ns", 0);
        clk             = 1'b0;
        rst_n           = 1'b0;
        stall           = 1'b0;
        flush           = 1'b0;
        executed        = 1'b0;
        taken           = 1'b0;
        fetch_pc        = UNKNOWN_PC;
        resolved_pc     = '0;
        resolved_target = '0;
        lfsr            = 32'h3e86_40c7;
        seen_pred       = 1'b0;
        timed_out       = 1'b0;
        err_next        = 0;
        err_pred        = 0;
        err_mis         = 0;
        err_other       = 0;
        for (int i = 0; i < `BPU_BTB_ENTRIES; i++) begin
            m_valid[i] = 1'b0;
        end
        for (int i = 0; i < `BPU_PHT_ENTRIES; i++) begin
            m_pht[i] = STRONG_NT;
        end
        m_ghr = '0;
        compute_expected();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        // Unknown address right after reset and then the first taken resolution at P
        drive_cycle(UNKNOWN_PC, 1'b0, 1'b0, 1'b0, 1'b0, '0, '0);
        drive_cycle(UNKNOWN_PC, 1'b0, 1'b0, 1'b1, 1'b1, pool_pc(1), pool_pc(1) + 32'h800);
        train_until_taken(pool_pc(1), pool_pc(1) + 32'h800, timed_out);
        if (!timed_out) begin
            // Not-taken outcome against the queued taken prediction and then an empty FIFO
            drive_cycle(UNKNOWN_PC, 1'b0, 1'b0, 1'b1, 1'b0, pool_pc(1), pool_pc(1) + 32'h800);
            drive_cycle(UNKNOWN_PC, 1'b0, 1'b0, 1'b1, 1'b0, pool_pc(1), pool_pc(1) + 32'h800);
            // A flush drops the queued prediction
            drive_cycle(pool_pc(1), 1'b0, 1'b0, 1'b0, 1'b0, '0, '0);
            drive_cycle(UNKNOWN_PC, 1'b0, 1'b1, 1'b0, 1'b0, '0, '0);
            drive_cycle(UNKNOWN_PC, 1'b0, 1'b0, 1'b1, 1'b1, pool_pc(1), pool_pc(1) + 32'h800);
            // A stalled fetch is never queued
            drive_cycle(pool_pc(1), 1'b1, 1'b0, 1'b0, 1'b0, '0, '0);
            drive_cycle(UNKNOWN_PC, 1'b0, 1'b0, 1'b1, 1'b1, pool_pc(1), pool_pc(1) + 32'h800);
            // Taken resolutions on an empty FIFO fill the history with ones again
            // The next fetch at P then reads the counter left at WEAK_NT by the mispredict
            repeat ($bits(ghr_t)) begin
                drive_cycle(UNKNOWN_PC, 1'b0, 1'b0, 1'b1, 1'b1, pool_pc(1), pool_pc(1) + 32'h800);
            end
            // Resolution together with a flush still trains the counter up to WEAK_T
            drive_cycle(pool_pc(1), 1'b0, 1'b0, 1'b0, 1'b0, '0, '0);
            drive_cycle(UNKNOWN_PC, 1'b0, 1'b1, 1'b1, 1'b1, pool_pc(1), pool_pc(1) + 32'h800);
            // The history is unchanged, so the same counter now predicts taken
            drive_cycle(pool_pc(1), 1'b0, 1'b0, 1'b0, 1'b0, '0, '0);
            run_random();
        end
        finish_run();
    end

endmodule : tb_bpu_top

//--- vlog.f
+incdir+hw
hw/bpu_addr_pkg.sv
hw/bpu_counter_pkg.sv
hw/branch_target_buffer.sv
hw/gshare_predictor.sv
hw/fetch_redirect.sv
hw/bpu_top.sv
test/tb_bpu_top.sv
